// File: all.f
+incdir+verification
source/aluOpsPkg.sv
source/stationConfigPkg.sv
source/operandCapture.sv
source/stationEntries.sv
source/executeStage.sv
source/reservationStation.sv
verification/reservationStationTb.sv

// File: Makefile
VERILATOR := verilator
TOP       := reservationStationTb
FILELIST  := all.f
LINTFLAGS := --lint-only -Wall --timing
SIMFLAGS  := --binary --timing --assert
BUILDDIR  := obj_dir
LOG       := sim.log
FAILTEXT  := Result: FAILED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAILTEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: verification/stationTestTasks.svh
`ifndef stationTestTasksSvh
`define stationTestTasksSvh

task automatic abortRun(input string reason);
  $display("%s", reason);
  $display("Result: FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic checkValue(input string testName, input logic [dataWidth-1:0] expected,
                          input logic [dataWidth-1:0] actual);
  if (actual !== expected) begin
    abortRun($sformatf("Fail %s: expected %h, actual %h", testName, expected, actual));
  end
endtask

task automatic checkTag(input string testName, input logic [robTagWidth-1:0] expected,
                        input logic [robTagWidth-1:0] actual);
  if (actual !== expected) begin
    abortRun($sformatf("Fail %s: expected tag %0d, actual tag %0d", testName, expected, actual));
  end
endtask

task automatic checkFlag(input string testName, input logic expected, input logic actual);
  if (actual !== expected) begin
    abortRun($sformatf("Fail %s: expected %b, actual %b", testName, expected, actual));
  end
endtask

// reference ALU with the whole second operand as shift amount
function automatic logic [dataWidth-1:0] expectedResult(input aluOpT op,
    input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
  logic signed [dataWidth-1:0] sa;
  logic signed [dataWidth-1:0] sb;
  logic [dataWidth-1:0]        result;
  logic                        wideShift;
  sa        = a;
  sb        = b;
  result    = '0;
  wideShift = (b >= dataWidth);  // everything shifted out
  case (op)
    ADD:     result = a + b;
    SUB:     result = a + ~b + 1;
    XOR:     result = a ^ b;
    OR:      result = a | b;
    AND:     result = a & b;
    SLL:     result = wideShift ? '0 : a << b[4:0];
    SRL:     result = wideShift ? '0 : a >> b[4:0];
    SRA:     result = wideShift ? {dataWidth{a[dataWidth-1]}} : $unsigned(sa >>> b[4:0]);
    EQ:      result[0] = (a == b);
    NE:      result[0] = (a != b);
    LT:      result[0] = (sa < sb);
    LTU:     result[0] = (a < b);
    GE:      result[0] = !(sa < sb);
    GEU:     result[0] = !(a < b);
    default: result = '0;
  endcase
  return result;
endfunction

task automatic stepCycle();
  @(posedge clockIn);
  #(driveDelay);
endtask

task automatic addOperation(input aluOpT op, input logic [robTagWidth-1:0] tag,
    input logic [dataWidth-1:0] value1, input logic hasDep1, input logic [robTagWidth-1:0] dep1,
    input logic [dataWidth-1:0] value2, input logic hasDep2, input logic [robTagWidth-1:0] dep2);
  addValid   = 1'b1;
  addOp      = op;
  addRobTag  = tag;
  addValue1  = value1;
  addHasDep1 = hasDep1;
  addDepTag1 = dep1;
  addValue2  = value2;
  addHasDep2 = hasDep2;
  addDepTag2 = dep2;
  stepCycle();
  addValid = 1'b0;
endtask

task automatic addIndependent(input aluOpT op, input logic [robTagWidth-1:0] tag,
                              input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
  addOperation(op, tag, a, 1'b0, '0, b, 1'b0, '0);
endtask

task automatic broadcastLoad(input logic [robTagWidth-1:0] tag, input logic [dataWidth-1:0] value);
  lsbUpdate = 1'b1;
  lsbRobTag = tag;
  lsbValue  = value;
  stepCycle();
  lsbUpdate = 1'b0;
endtask

task automatic waitForUpdate(input string testName);
  int waited;
  waited = 0;
  while (!update && waited < updateWaitLimit) begin
    stepCycle();
    waited++;
  end
  if (!update) begin
    abortRun($sformatf("%s: no update pulse within %0d cycles", testName, updateWaitLimit));
  end
endtask

task automatic expectUpdate(input string testName, input logic [robTagWidth-1:0] expTag,
                            input logic [dataWidth-1:0] expValue);
  waitForUpdate(testName);
  checkTag(testName, expTag, updateRobTag);
  checkValue(testName, expValue, updateValue);
endtask

task automatic expectQuiet(input string testName, input int cycles);
  repeat (cycles) begin
    stepCycle();
    checkFlag(testName, 1'b0, update);
  end
endtask

task automatic afterReset();
  checkFlag("afterReset update", 1'b0, update);
  checkFlag("afterReset full", 1'b0, full);
endtask

task automatic sweepOpcodes();
  aluOpT                  op;
  logic [dataWidth-1:0]   a;
  logic [dataWidth-1:0]   b;
  logic [robTagWidth-1:0] tag;
  string                  testName;
  for (int pass = 0; pass < 2; pass++) begin
    for (int i = 0; i < opCount; i++) begin
      op       = aluOpT'(i[3:0]);
      tag      = robTagWidth'(i);
      testName = $sformatf("sweepOpcodes %s pass %0d", op.name(), pass);
      a        = $urandom;
      b        = (pass == 0) ? $urandom : $urandom_range(0, 39);  // small shift amounts
      if (pass == 1 && (op == EQ || op == NE)) b = a;
      addIndependent(op, tag, a, b);
      stepCycle();
      checkFlag(testName, 1'b0, update);
      stepCycle();
      checkFlag(testName, 1'b1, update);  // two cycles after the add
      checkTag(testName, tag, updateRobTag);
      checkValue(testName, expectedResult(op, a, b), updateValue);
      stepCycle();
      checkFlag(testName, 1'b0, update);  // single pulse
    end
  end
endtask

// mode 0 wakes a stored entry, mode 1 ALU stage bypass, mode 2 broadcast bypass
task automatic forwardResult();
  logic [dataWidth-1:0] a1;
  logic [dataWidth-1:0] a2;
  logic [dataWidth-1:0] b2;
  logic [dataWidth-1:0] resultA;
  string                testName;
  for (int mode = 0; mode < 3; mode++) begin
    testName = $sformatf("forwardResult mode %0d", mode);
    a1       = $urandom;
    a2       = $urandom;
    b2       = $urandom;
    resultA  = expectedResult(SUB, a1, a2);
    addIndependent(SUB, 4'd3, a1, a2);
    if (mode == 2) begin
      expectUpdate(testName, 4'd3, resultA);  // A on the broadcast now
    end else if (mode == 1) begin
      stepCycle();  // A in the ALU stage
    end
    addOperation(XOR, 4'd4, '0, 1'b1, 4'd3, b2, 1'b0, '0);
    if (mode != 2) expectUpdate(testName, 4'd3, resultA);
    stepCycle();
    expectUpdate(testName, 4'd4, expectedResult(XOR, resultA, b2));
    stepCycle();
  end
endtask

task automatic wakeFromLoadStore();
  logic [dataWidth-1:0] loaded;
  loaded = $urandom;
  addOperation(ADD, 4'd6, '0, 1'b1, 4'd15, '0, 1'b1, 4'd15);
  expectQuiet("wakeFromLoadStore waiting", 8);
  broadcastLoad(4'd15, loaded);
  expectUpdate("wakeFromLoadStore", 4'd6, expectedResult(ADD, loaded, loaded));
  expectQuiet("wakeFromLoadStore single update", 6);
endtask

task automatic fillAndDrain();
  logic [dataWidth-1:0] loaded;
  logic [dataWidth-1:0] offset [fillCount];
  int                   seen [fillCount];
  int                   t;
  loaded = $urandom;
  for (int i = 0; i < fillCount; i++) begin
    offset[i] = $urandom;
    seen[i]   = 0;
    checkFlag("fillAndDrain full before add", 1'b0, full);
    addOperation(ADD, robTagWidth'(i), '0, 1'b1, 4'd15, offset[i], 1'b0, '0);
  end
  checkFlag("fillAndDrain full raised", 1'b1, full);
  broadcastLoad(4'd15, loaded);  // wakes every entry at once
  for (int n = 0; n < fillCount; n++) begin
    waitForUpdate("fillAndDrain");
    checkFlag("fillAndDrain tag in range", 1'b1, updateRobTag < fillCount);
    t = int'(updateRobTag);
    checkFlag("fillAndDrain repeated tag", 1'b0, seen[t] != 0);
    seen[t]++;
    checkValue("fillAndDrain", expectedResult(ADD, loaded, offset[t]), updateValue);
    stepCycle();
  end
  expectQuiet("fillAndDrain drained", 4);
  for (int i = 0; i < fillCount; i++) begin
    checkFlag($sformatf("fillAndDrain tag %0d seen once", i), 1'b1, seen[i] == 1);
  end
  checkFlag("fillAndDrain full cleared", 1'b0, full);
endtask

task automatic ignoreWhileStalled();
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  a       = $urandom;
  b       = $urandom;
  readyIn = 1'b0;
  addIndependent(OR, 4'd9, a, b);  // dropped while readyIn is low
  expectQuiet("ignoreWhileStalled stalled", 8);
  readyIn = 1'b1;
  expectQuiet("ignoreWhileStalled released", 4);
  addIndependent(AND, 4'd10, a, b);
  expectUpdate("ignoreWhileStalled fresh add", 4'd10, expectedResult(AND, a, b));
  expectQuiet("ignoreWhileStalled single update", 3);
endtask

`endif

// File: verification/reservationStationTb.sv
`timescale 1ns/1ps

module reservationStationTb
  import aluOpsPkg::*, stationConfigPkg::*;
;

  localparam int resetCycles     = 16;
  localparam int timeoutCycles   = 2000;  // several times the summed test length
  localparam int updateWaitLimit = 20;
  localparam int driveDelay      = 1;     // ns after the rising edge
  localparam int opCount         = 14;
  localparam int fillCount       = fullThreshold + 1;  // first occupancy with full high

  logic                   clockIn;
  logic                   resetIn;
  logic                   readyIn;
  logic                   addValid;
  aluOpT                  addOp;
  logic [robTagWidth-1:0] addRobTag;
  logic [dataWidth-1:0]   addValue1;
  logic                   addHasDep1;
  logic [robTagWidth-1:0] addDepTag1;
  logic [dataWidth-1:0]   addValue2;
  logic                   addHasDep2;
  logic [robTagWidth-1:0] addDepTag2;
  logic                   lsbUpdate;
  logic [robTagWidth-1:0] lsbRobTag;
  logic [dataWidth-1:0]   lsbValue;
  logic                   full;
  logic                   update;
  logic [robTagWidth-1:0] updateRobTag;
  logic [dataWidth-1:0]   updateValue;
  int                     cycleCount = 0;

  reservationStation reservationStation_inst (.*);

  `include "stationTestTasks.svh"

  initial begin
    clockIn = 1'b0;
    forever #5 clockIn = ~clockIn;
  end

  always @(posedge clockIn) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      abortRun($sformatf("timeout, run did not finish within %0d cycles", timeoutCycles));
    end
  end

  initial begin
    void'($urandom(82139));
    resetIn    = 1'b1;
    readyIn    = 1'b1;
    addValid   = 1'b0;
    addOp      = ADD;
    addRobTag  = '0;
    addValue1  = '0;
    addHasDep1 = 1'b0;
    addDepTag1 = '0;
    addValue2  = '0;
    addHasDep2 = 1'b0;
    addDepTag2 = '0;
    lsbUpdate  = 1'b0;
    lsbRobTag  = '0;
    lsbValue   = '0;

    repeat (resetCycles) @(posedge clockIn);
    #(driveDelay);
    resetIn = 1'b0;

    afterReset();
    sweepOpcodes();
    forwardResult();
    wakeFromLoadStore();
    fillAndDrain();
    ignoreWhileStalled();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: source/reservationStation.sv
`timescale 1ns/1ps

module reservationStation
  import aluOpsPkg::*, stationConfigPkg::*;
(
  input  logic                   clockIn,
  input  logic                   resetIn,
  input  logic                   readyIn,
  // instruction unit
  input  logic                   addValid,
  input  aluOpT                  addOp,
  input  logic [robTagWidth-1:0] addRobTag,
  input  logic [dataWidth-1:0]   addValue1,
  input  logic                   addHasDep1,
  input  logic [robTagWidth-1:0] addDepTag1,
  input  logic [dataWidth-1:0]   addValue2,
  input  logic                   addHasDep2,
  input  logic [robTagWidth-1:0] addDepTag2,
  output logic                   full,
  // load/store buffer
  input  logic                   lsbUpdate,
  input  logic [robTagWidth-1:0] lsbRobTag,
  input  logic [dataWidth-1:0]   lsbValue,
  // result broadcast
  output logic                   update,
  output logic [robTagWidth-1:0] updateRobTag,
  output logic [dataWidth-1:0]   updateValue
);

  logic                   aluBusy;
  logic [robTagWidth-1:0] aluRobTag;
  logic [dataWidth-1:0]   aluResult;
  logic [dataWidth-1:0]   resolvedValue1;
  logic                   resolvedHasDep1;
  logic [dataWidth-1:0]   resolvedValue2;
  logic                   resolvedHasDep2;
  logic                   issueValid;
  aluOpT                  issueOp;
  logic [robTagWidth-1:0] issueRobTag;
  logic [dataWidth-1:0]   issueValue1;
  logic [dataWidth-1:0]   issueValue2;

  operandCapture operandCapture_inst (.*);

  stationEntries stationEntries_inst (.*);

  executeStage executeStage_inst (
    .clockIn      (clockIn),
    .resetIn      (resetIn),
    .readyIn      (readyIn),
    .issueValid   (issueValid),
    .issueOp      (issueOp),
    .issueRobTag  (issueRobTag),
    .issueValue1  (issueValue1),
    .issueValue2  (issueValue2),
    .aluBusy      (aluBusy),
    .aluRobTag    (aluRobTag),
    .aluResult    (aluResult),
    .update       (update),
    .updateRobTag (updateRobTag),
    .updateValue  (updateValue)
  );

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage
  import aluOpsPkg::*, stationConfigPkg::*;
(
  input  logic                   clockIn,
  input  logic                   resetIn,
  input  logic                   readyIn,
  input  logic                   issueValid,
  input  aluOpT                  issueOp,
  input  logic [robTagWidth-1:0] issueRobTag,
  input  logic [dataWidth-1:0]   issueValue1,
  input  logic [dataWidth-1:0]   issueValue2,
  output logic                   aluBusy,
  output logic [robTagWidth-1:0] aluRobTag,
  output logic [dataWidth-1:0]   aluResult,
  output logic                   update,
  output logic [robTagWidth-1:0] updateRobTag,
  output logic [dataWidth-1:0]   updateValue
);

  aluOpT                stageOp;
  logic [dataWidth-1:0] stageValue1;
  logic [dataWidth-1:0] stageValue2;

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      aluBusy <= 1'b0;
    end else if (readyIn) begin
      aluBusy <= issueValid;
    end
  end

  always_ff @(posedge clockIn) begin
    if (readyIn) begin
      stageOp     <= issueOp;
      aluRobTag   <= issueRobTag;
      stageValue1 <= issueValue1;
      stageValue2 <= issueValue2;
    end
  end

  always_comb begin
    case (stageOp)
      ADD:     aluResult = stageValue1 + stageValue2;
      SUB:     aluResult = stageValue1 - stageValue2;
      XOR:     aluResult = stageValue1 ^ stageValue2;
      OR:      aluResult = stageValue1 | stageValue2;
      AND:     aluResult = stageValue1 & stageValue2;
      SLL:     aluResult = stageValue1 << stageValue2;  // whole operand as amount
      SRL:     aluResult = stageValue1 >> stageValue2;
      SRA:     aluResult = $unsigned($signed(stageValue1) >>> stageValue2);
      EQ:      aluResult = dataWidth'(stageValue1 == stageValue2);
      NE:      aluResult = dataWidth'(stageValue1 != stageValue2);
      LT:      aluResult = dataWidth'($signed(stageValue1) < $signed(stageValue2));
      LTU:     aluResult = dataWidth'(stageValue1 < stageValue2);
      GE:      aluResult = dataWidth'($signed(stageValue1) >= $signed(stageValue2));
      GEU:     aluResult = dataWidth'(stageValue1 >= stageValue2);
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      update       <= 1'b0;
      updateRobTag <= '0;
      updateValue  <= '0;
    end else if (readyIn) begin
      update       <= aluBusy;
      updateRobTag <= aluBusy ? aluRobTag : '0;  // zero when idle
      updateValue  <= aluBusy ? aluResult : '0;
    end
  end

  noUpdateAfterReset: assert property (@(posedge clockIn) $fell(resetIn) |=> !update);

endmodule

// File: source/stationEntries.sv
`timescale 1ns/1ps

module stationEntries
  import aluOpsPkg::*, stationConfigPkg::*;
(
  input  logic                   clockIn,
  input  logic                   resetIn,
  input  logic                   readyIn,
  input  logic                   addValid,
  input  aluOpT                  addOp,
  input  logic [robTagWidth-1:0] addRobTag,
  input  logic [robTagWidth-1:0] addDepTag1,
  input  logic [robTagWidth-1:0] addDepTag2,
  input  logic [dataWidth-1:0]   resolvedValue1,
  input  logic                   resolvedHasDep1,
  input  logic [dataWidth-1:0]   resolvedValue2,
  input  logic                   resolvedHasDep2,
  input  logic                   lsbUpdate,
  input  logic [robTagWidth-1:0] lsbRobTag,
  input  logic [dataWidth-1:0]   lsbValue,
  input  logic                   aluBusy,
  input  logic [robTagWidth-1:0] aluRobTag,
  input  logic [dataWidth-1:0]   aluResult,
  output logic                   full,
  output logic                   issueValid,
  output aluOpT                  issueOp,
  output logic [robTagWidth-1:0] issueRobTag,
  output logic [dataWidth-1:0]   issueValue1,
  output logic [dataWidth-1:0]   issueValue2
);

  logic [entryCount-1:0]  entryValid;
  aluOpT                  entryOp      [entryCount];
  logic [robTagWidth-1:0] entryRobTag  [entryCount];
  logic [dataWidth-1:0]   entryValue1  [entryCount];
  logic [dataWidth-1:0]   entryValue2  [entryCount];
  logic [entryCount-1:0]  entryHasDep1;
  logic [entryCount-1:0]  entryHasDep2;
  logic [robTagWidth-1:0] entryDepTag1 [entryCount];
  logic [robTagWidth-1:0] entryDepTag2 [entryCount];

  logic [entryIndexWidth:0]   occupancy;  // one bit wider, holds entryCount
  logic [entryCount-1:0]      readyMask;
  logic [entryIndexWidth-1:0] freeIndex;
  logic [entryIndexWidth-1:0] issueIndex;

  assign readyMask = entryValid & ~entryHasDep1 & ~entryHasDep2;
  assign full      = occupancy > fullThreshold;

  // priority encoders, lowest index wins
  always_comb begin
    freeIndex  = '0;
    issueIndex = '0;
    for (int i = entryCount - 1; i >= 0; i--) begin
      if (!entryValid[i]) freeIndex = entryIndexWidth'(i);
      if (readyMask[i]) issueIndex = entryIndexWidth'(i);
    end
  end

  assign issueValid  = |readyMask;
  assign issueOp     = entryOp[issueIndex];
  assign issueRobTag = entryRobTag[issueIndex];
  assign issueValue1 = entryValue1[issueIndex];
  assign issueValue2 = entryValue2[issueIndex];

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      entryValid <= '0;
      occupancy  <= '0;
    end else if (readyIn) begin
      // wakeup of stored operands
      for (int i = 0; i < entryCount; i++) begin
        if (entryValid[i] && entryHasDep1[i]) begin
          if (lsbUpdate && (entryDepTag1[i] == lsbRobTag)) begin
            entryValue1[i]  <= lsbValue;
            entryHasDep1[i] <= 1'b0;
          end else if (aluBusy && (entryDepTag1[i] == aluRobTag)) begin
            entryValue1[i]  <= aluResult;
            entryHasDep1[i] <= 1'b0;
          end
        end
        if (entryValid[i] && entryHasDep2[i]) begin
          if (lsbUpdate && (entryDepTag2[i] == lsbRobTag)) begin
            entryValue2[i]  <= lsbValue;
            entryHasDep2[i] <= 1'b0;
          end else if (aluBusy && (entryDepTag2[i] == aluRobTag)) begin
            entryValue2[i]  <= aluResult;
            entryHasDep2[i] <= 1'b0;
          end
        end
      end

      if (addValid) begin  // free slot, never the issuing one
        entryValid[freeIndex]   <= 1'b1;
        entryOp[freeIndex]      <= addOp;
        entryRobTag[freeIndex]  <= addRobTag;
        entryValue1[freeIndex]  <= resolvedValue1;
        entryHasDep1[freeIndex] <= resolvedHasDep1;
        entryDepTag1[freeIndex] <= addDepTag1;
        entryValue2[freeIndex]  <= resolvedValue2;
        entryHasDep2[freeIndex] <= resolvedHasDep2;
        entryDepTag2[freeIndex] <= addDepTag2;
      end

      if (issueValid) entryValid[issueIndex] <= 1'b0;

      occupancy <= occupancy + {{entryIndexWidth{1'b0}}, addValid}
                             - {{entryIndexWidth{1'b0}}, issueValid};
    end
  end

  // instruction unit must respect full
  addWhileFull: assert property (
    @(posedge clockIn) disable iff (resetIn)
    readyIn |-> !(addValid && full)
  );

  occupancyBound: assert property (
    @(posedge clockIn) disable iff (resetIn)
    occupancy <= entryCount
  );

endmodule

// File: source/operandCapture.sv
`timescale 1ns/1ps

module operandCapture
  import aluOpsPkg::*, stationConfigPkg::*;
(
  input  logic [dataWidth-1:0]   addValue1,
  input  logic                   addHasDep1,
  input  logic [robTagWidth-1:0] addDepTag1,
  input  logic [dataWidth-1:0]   addValue2,
  input  logic                   addHasDep2,
  input  logic [robTagWidth-1:0] addDepTag2,
  input  logic                   lsbUpdate,
  input  logic [robTagWidth-1:0] lsbRobTag,
  input  logic [dataWidth-1:0]   lsbValue,
  input  logic                   aluBusy,
  input  logic [robTagWidth-1:0] aluRobTag,
  input  logic [dataWidth-1:0]   aluResult,
  input  logic                   update,
  input  logic [robTagWidth-1:0] updateRobTag,
  input  logic [dataWidth-1:0]   updateValue,
  output logic [dataWidth-1:0]   resolvedValue1,
  output logic                   resolvedHasDep1,
  output logic [dataWidth-1:0]   resolvedValue2,
  output logic                   resolvedHasDep2
);

  // load/store first, then ALU stage, then broadcast register
  function automatic void resolveOperand(
    input  logic [dataWidth-1:0]   value,
    input  logic                   hasDep,
    input  logic [robTagWidth-1:0] depTag,
    output logic [dataWidth-1:0]   outValue,
    output logic                   outHasDep
  );
    outValue  = value;
    outHasDep = hasDep;
    if (hasDep) begin
      if (lsbUpdate && (depTag == lsbRobTag)) begin
        outValue  = lsbValue;
        outHasDep = 1'b0;
      end else if (aluBusy && (depTag == aluRobTag)) begin
        outValue  = aluResult;  // produced this cycle
        outHasDep = 1'b0;
      end else if (update && (depTag == updateRobTag)) begin
        outValue  = updateValue;
        outHasDep = 1'b0;
      end
    end
  endfunction

  always_comb begin
    resolveOperand(addValue1, addHasDep1, addDepTag1, resolvedValue1, resolvedHasDep1);
    resolveOperand(addValue2, addHasDep2, addDepTag2, resolvedValue2, resolvedHasDep2);
  end

endmodule

// File: source/stationConfigPkg.sv
package stationConfigPkg;

  localparam int robTagWidth = 4;  // reorder buffer tag

  localparam int entryCount = 16;
  localparam int entryIndexWidth = 4;

  // full goes high at 14 entries, room for adds in flight
  localparam int fullThreshold = 13;

endpackage

// File: source/aluOpsPkg.sv
package aluOpsPkg;

  localparam int dataWidth = 32;  // operand and result width

  // ALU operations, encodings fixed by the instruction unit
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    XOR = 4'd2,
    OR  = 4'd3,
    AND = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    SRA = 4'd7,
    EQ  = 4'd8,
    NE  = 4'd9,
    LT  = 4'd10,  // signed
    LTU = 4'd11,
    GE  = 4'd12,  // signed
    GEU = 4'd13
  } aluOpT;

endpackage
